// File: bk_io_pkg.sv
//////////////////////////////
// Shared types and constants for the BK0011M I/O subsystem.
// Modules refer to these by scoped names, bk_io_pkg::name.
//////////////////////////////

package bk_io_pkg;

	////////// Bus //////////

	// One 16-bit bus data word
	typedef logic [15:0] word_t;

	// CPU bus request, as seen by the peripheral blocks
	typedef struct packed {
		// Data strobe, read or write
		logic stb;
		logic we;
		// Byte enables, bit 0 low byte, bit 1 high byte
		logic [1:0] wtbt;
		// System register select
		logic sel_sys;
		// Parallel port select
		logic sel_port;
		// CPU write data
		word_t dout;
	} bus_req_t;

	////////// Mouse //////////

	// Mouse report from the host side
	typedef struct packed {
		// Flips on every new report
		logic toggle;
		// Bit 0 left, bit 1 right
		logic [1:0] buttons;
		// Two's complement motion
		logic signed [8:0] dx;
		logic signed [8:0] dy;
	} mouse_pkt_t;

	// Motion must exceed these to register as a step
	localparam int MOUSE_POS_THRESH = 3;
	localparam int MOUSE_NEG_THRESH = 2;

	////////// Audio //////////

	// Speaker level, three bits from the system register
	typedef logic [2:0] spk_t;

	// Stereo sample, unsigned
	typedef struct packed {
		logic [15:0] left;
		logic [15:0] right;
	} audio_t;

	////////// Register bit positions //////////

	// System register, write side
	localparam int SYS_BIT_SPK_HI   = 6;
	localparam int SYS_BIT_SPK_MID  = 5;
	localparam int SYS_BIT_SPK_LO   = 2;
	localparam int SYS_BIT_STOP_BLK = 12;
	// Set in a write to protect the STOP block and high bits
	localparam int SYS_BIT_RO_GUARD = 11;

	// Port, mouse enable in the low byte
	localparam int PORT_BIT_MOUSE_EN = 3;

endpackage

// File: bk_clock_enables.sv
//////////////////////////////
// CPU clock-enable generator with model select and turbo.
// Emits a positive and a negative enable, half a period apart.
//////////////////////////////

`timescale 1ns/1ps

module bk_clock_enables #(
	parameter int CPU_DIV_11M = 24,
	parameter int CPU_DIV_10  = 32
) (
	input  logic clk_sys,
	input  logic rst,
	input  logic bk0010,
	input  logic turbo_req,
	input  logic bus_sync,
	output logic ce_cpu_p,
	output logic ce_cpu_n
);

	localparam int MAX_DIV = (CPU_DIV_10 > CPU_DIV_11M) ? CPU_DIV_10 : CPU_DIV_11M;
	localparam int CNT_W   = $clog2(MAX_DIV) + 1;

	logic             turbo;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] period;
	logic [CNT_W-1:0] half;

	// Period for the selected model, halved in turbo
	assign period = (bk0010 ? CNT_W'(CPU_DIV_10) : CNT_W'(CPU_DIV_11M)) >> turbo;
	assign half   = period >> 1;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cnt      <= '0;
			turbo    <= 1'b0;
			ce_cpu_p <= 1'b0;
			ce_cpu_n <= 1'b0;
		end else begin
			if (cnt == period - 1'b1) begin
				cnt <= '0;
				// Only switch speed between bus cycles
				if (!bus_sync)
					turbo <= turbo_req;
			end else begin
				cnt <= cnt + 1'b1;
			end
			ce_cpu_p <= (cnt == '0);
			ce_cpu_n <= (cnt == half);
		end
	end

	// The two phases must never overlap
	assert property (@(posedge clk_sys) disable iff (rst) !(ce_cpu_p && ce_cpu_n))
		else $error("CPU clock enables high in the same cycle");

endmodule

// File: bk_sysreg.sv
//////////////////////////////
// System register with supervisor flag, speaker bits and
// STOP-key interrupt block. Read data is zero when not selected.
//////////////////////////////

`timescale 1ns/1ps

module bk_sysreg #(
	parameter logic [7:0] START_ADDR = 8'h80
) (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  bk_io_pkg::bus_req_t   bus,
	input  logic                  bk0010,
	input  logic                  key_down,
	input  logic                  key_stop,
	output bk_io_pkg::word_t      rd_word,
	output bk_io_pkg::spk_t       spk,
	output logic                  irq_stop
);

	logic acc;
	logic acc_q;
	logic wr;
	logic wr_q;
	logic super_flg;
	logic stop_blk;
	logic guard;

	assign acc   = bus.stb & bus.sel_sys;
	assign wr    = acc & bus.we;
	assign guard = bus.dout[bk_io_pkg::SYS_BIT_RO_GUARD];

	////////// Register state //////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			acc_q     <= 1'b0;
			wr_q      <= 1'b0;
			super_flg <= 1'b0;
			stop_blk  <= 1'b0;
			spk       <= '0;
		end else begin
			acc_q <= acc;
			wr_q  <= wr;

			// Supervisor flag tracks the type of the last access
			if (acc && !acc_q)
				super_flg <= bus.we;

			if (wr && !wr_q) begin
				if (!guard && bus.wtbt[1])
					stop_blk <= bus.dout[bk_io_pkg::SYS_BIT_STOP_BLK];
				if (bus.wtbt[0] && (!bus.wtbt[1] || !guard)) begin
					spk[2] <= bus.dout[bk_io_pkg::SYS_BIT_SPK_HI];
					spk[1] <= bus.dout[bk_io_pkg::SYS_BIT_SPK_MID];
					// BK0010 has no low speaker bit
					spk[0] <= bus.dout[bk_io_pkg::SYS_BIT_SPK_LO] & !bk0010;
				end
			end
		end
	end

	////////// Read side //////////
	always_comb begin
		if (bus.sel_sys)
			rd_word = {START_ADDR, 1'b1, ~key_down, 3'b000, super_flg, 2'b00};
		else
			rd_word = '0;
	end

	assign irq_stop = key_stop & ~stop_blk;

	// Address decode upstream must keep the selects exclusive
	assert property (@(posedge clk_sys) disable iff (rst) bus.stb |-> !(bus.sel_sys && bus.sel_port))
		else $error("System register and port selected together");

endmodule

// File: bk_port_io.sv
//////////////////////////////
// Parallel port shared by joystick and mouse, plus the Covox latch.
// Mouse reports are turned into sticky motion and button bits.
//////////////////////////////

`timescale 1ns/1ps

module bk_port_io (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  bk_io_pkg::bus_req_t    bus,
	input  logic                   covox_en,
	input  bk_io_pkg::word_t       joystick,
	input  bk_io_pkg::mouse_pkt_t  mouse,
	output bk_io_pkg::word_t       rd_word,
	output bk_io_pkg::word_t       covox
);

	logic       port_wr;
	logic       port_wr_q;
	logic       mouse_wr;
	logic       mouse_wr_q;
	logic       toggle_q;
	logic       mouse_en;
	logic       mouse_view;
	logic [6:0] mouse_state;
	logic [8:0] dx_inv;
	logic [8:0] dy_inv;

	assign port_wr  = bus.stb & bus.sel_port & bus.we;
	// Mouse control shares the low byte unless Covox owns the port
	assign mouse_wr = port_wr & bus.wtbt[0] & ~covox_en;
	assign dx_inv   = ~mouse.dx;
	assign dy_inv   = ~mouse.dy;

	////////// Covox latch //////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			port_wr_q <= 1'b0;
			covox     <= '0;
		end else begin
			port_wr_q <= port_wr;
			if (port_wr && !port_wr_q) begin
				if (bus.wtbt[0])
					covox[7:0] <= bus.dout[7:0];
				if (bus.wtbt[1])
					covox[15:8] <= bus.dout[15:8];
			end
		end
	end

	////////// Mouse and joystick //////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			mouse_wr_q  <= 1'b0;
			toggle_q    <= 1'b0;
			mouse_en    <= 1'b0;
			mouse_view  <= 1'b0;
			mouse_state <= '0;
		end else begin
			mouse_wr_q <= mouse_wr;
			toggle_q   <= mouse.toggle;

			if (|joystick)
				mouse_view <= 1'b0;

			if (mouse_wr && !mouse_wr_q) begin
				mouse_en <= bus.dout[bk_io_pkg::PORT_BIT_MOUSE_EN];
				if (!bus.dout[bk_io_pkg::PORT_BIT_MOUSE_EN])
					mouse_state[3:0] <= '0;
			end

			// New report, a report wins over the joystick
			if (mouse.toggle != toggle_q) begin
				mouse_state[6] <= mouse.buttons[1];
				mouse_state[5] <= mouse.buttons[0];
				mouse_view     <= 1'b1;
				if (mouse_en) begin
					// Y axis, bit 0 up and bit 2 down
					if (!mouse_state[0] && !mouse_state[2]) begin
						if (!mouse.dy[8] && (mouse.dy > 9'(bk_io_pkg::MOUSE_POS_THRESH)))
							mouse_state[0] <= 1'b1;
						if (mouse.dy[8] && (dy_inv > 9'(bk_io_pkg::MOUSE_NEG_THRESH)))
							mouse_state[2] <= 1'b1;
					end
					// X axis, bit 1 and bit 3
					if (!mouse_state[1] && !mouse_state[3]) begin
						if (!mouse.dx[8] && (mouse.dx > 9'(bk_io_pkg::MOUSE_POS_THRESH)))
							mouse_state[1] <= 1'b1;
						if (mouse.dx[8] && (dx_inv > 9'(bk_io_pkg::MOUSE_NEG_THRESH)))
							mouse_state[3] <= 1'b1;
					end
				end
			end
		end
	end

	////////// Read side //////////
	always_comb begin
		if (!bus.sel_port)
			rd_word = '0;
		else if (mouse_view && !covox_en)
			rd_word = {9'b0, mouse_state};
		else
			rd_word = joystick;
	end

	// Opposite directions on one axis never latch together
	assert property (@(posedge clk_sys) disable iff (rst)
		!(mouse_state[0] && mouse_state[2]) && !(mouse_state[1] && mouse_state[3]))
		else $error("Mouse motion bits set in both directions");

endmodule

// File: bk_audio_mix.sv
//////////////////////////////
// Mixes speaker and Covox levels into a registered stereo sample.
//////////////////////////////

`timescale 1ns/1ps

module bk_audio_mix (
	input  logic                clk_sys,
	input  logic                rst,
	input  bk_io_pkg::spk_t     spk,
	input  bk_io_pkg::word_t    covox,
	input  logic                covox_en,
	output bk_io_pkg::audio_t   audio
);

	logic [9:0] spk_lvl;
	logic [9:0] lvl_l;
	logic [9:0] lvl_r;

	// Speaker sits under the Covox byte when both play
	assign spk_lvl = {2'b00, spk, 5'b00000};

	always_comb begin
		if (covox_en) begin
			// Left takes the low byte, right the high byte
			lvl_l = {1'b0, covox[7:0], 1'b0} + spk_lvl;
			lvl_r = {1'b0, covox[15:8], 1'b0} + spk_lvl;
		end else begin
			lvl_l = {spk, 7'b0000000};
			lvl_r = {spk, 7'b0000000};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			audio <= '0;
		end else begin
			audio.left  <= {lvl_l, 6'd0};
			audio.right <= {lvl_r, 6'd0};
		end
	end

endmodule

// File: bk_io.sv
//////////////////////////////
// I/O subsystem top level. Wires the clock enables, system
// register, port and mixer, and registers the merged read data.
//////////////////////////////

`timescale 1ns/1ps

module bk_io #(
	parameter int         CPU_DIV_11M = 24,
	parameter int         CPU_DIV_10  = 32,
	parameter logic [7:0] START_ADDR  = 8'h80
) (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  bk_io_pkg::bus_req_t    bus,
	input  logic                   bus_sync,
	input  logic                   bk0010,
	input  logic                   turbo_req,
	input  logic                   covox_en,
	input  logic                   key_down,
	input  logic                   key_stop,
	input  bk_io_pkg::word_t       joystick,
	input  bk_io_pkg::mouse_pkt_t  mouse,
	output logic                   ce_cpu_p,
	output logic                   ce_cpu_n,
	output bk_io_pkg::word_t       rd_data,
	output logic                   irq_stop,
	output bk_io_pkg::audio_t      audio
);

	bk_io_pkg::word_t sys_rd;
	bk_io_pkg::word_t port_rd;
	bk_io_pkg::word_t covox;
	bk_io_pkg::spk_t  spk;

	////////// Clocking //////////
	bk_clock_enables #(
		.CPU_DIV_11M (CPU_DIV_11M),
		.CPU_DIV_10  (CPU_DIV_10)
	) clk_en_i (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.bk0010    (bk0010),
		.turbo_req (turbo_req),
		.bus_sync  (bus_sync),
		.ce_cpu_p  (ce_cpu_p),
		.ce_cpu_n  (ce_cpu_n)
	);

	////////// Registers //////////
	bk_sysreg #(
		.START_ADDR (START_ADDR)
	) sysreg_i (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.bus      (bus),
		.bk0010   (bk0010),
		.key_down (key_down),
		.key_stop (key_stop),
		.rd_word  (sys_rd),
		.spk      (spk),
		.irq_stop (irq_stop)
	);

	bk_port_io port_i (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.bus      (bus),
		.covox_en (covox_en),
		.joystick (joystick),
		.mouse    (mouse),
		.rd_word  (port_rd),
		.covox    (covox)
	);

	bk_audio_mix mix_i (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.spk      (spk),
		.covox    (covox),
		.covox_en (covox_en),
		.audio    (audio)
	);

	// Unselected blocks return zero, so OR merges them
	always_ff @(posedge clk_sys) begin
		if (rst)
			rd_data <= '0;
		else
			rd_data <= sys_rd | port_rd;
	end

endmodule

// File: tb_bk_io.sv
//////////////////////////////
// Directed testbench for the BK0011M I/O subsystem.
// Runs each block through its rules and prints a closing summary.
//////////////////////////////

`timescale 1ns/1ps

module tb_bk_io;

	localparam logic [7:0] START_ADDR = 8'hc0;
	localparam int CLK_NS = 40;
	// Upper bound on cycles used by all tests together
	localparam int TEST_CYCLES = 1500;

	logic                  clk_sys;
	logic                  rst;
	bk_io_pkg::bus_req_t   bus;
	logic                  bus_sync;
	logic                  bk0010;
	logic                  turbo_req;
	logic                  covox_en;
	logic                  key_down;
	logic                  key_stop;
	bk_io_pkg::word_t      joystick;
	bk_io_pkg::mouse_pkt_t mouse;
	logic                  ce_cpu_p;
	logic                  ce_cpu_n;
	bk_io_pkg::word_t      rd_data;
	logic                  irq_stop;
	bk_io_pkg::audio_t     audio;

	int                    errors;
	string                 test_name;
	bk_io_pkg::spk_t       spk_exp;
	bk_io_pkg::word_t      covox_exp;

	bk_io #(
		.CPU_DIV_11M (24),
		.CPU_DIV_10  (32),
		.START_ADDR  (START_ADDR)
	) dut_i (
		.clk_sys (clk_sys), .rst (rst), .bus (bus), .bus_sync (bus_sync),
		.bk0010 (bk0010), .turbo_req (turbo_req), .covox_en (covox_en),
		.key_down (key_down), .key_stop (key_stop), .joystick (joystick),
		.mouse (mouse), .ce_cpu_p (ce_cpu_p), .ce_cpu_n (ce_cpu_n),
		.rd_data (rd_data), .irq_stop (irq_stop), .audio (audio)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_NS / 2) clk_sys = ~clk_sys;
	end

	// Watchdog with twice the test length as margin
	initial begin
		#(TEST_CYCLES * CLK_NS * 2);
		$display("Timeout: the tests did not finish in time");
		$display("Test failures found");
		$finish;
	end

	////////// Compare tasks //////////
	task automatic check_word(input bk_io_pkg::word_t exp, input bk_io_pkg::word_t act);
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: expected %h, actual %h", test_name, exp, act);
		end
	endtask

	task automatic check_audio(input bk_io_pkg::audio_t exp, input bk_io_pkg::audio_t act);
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: expected L=%h R=%h, actual L=%h R=%h",
				test_name, exp.left, exp.right, act.left, act.right);
		end
	endtask

	task automatic check_bit(input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: expected %b, actual %b", test_name, exp, act);
		end
	endtask

	////////// Expected values //////////
	// Start address on top, fixed one in bit 7, inverted key and supervisor flag
	function automatic bk_io_pkg::word_t sys_word(input logic kd, input logic sup);
		bk_io_pkg::word_t w;
		w       = '0;
		w[15:8] = START_ADDR;
		w[7]    = 1'b1;
		w[6]    = ~kd;
		w[2]    = sup;
		return w;
	endfunction

	function automatic bk_io_pkg::audio_t mix_expect(input bk_io_pkg::spk_t s,
			input bk_io_pkg::word_t cv, input logic cov_on);
		bk_io_pkg::audio_t a;
		logic [9:0]        l;
		logic [9:0]        r;
		if (cov_on) begin
			l = (10'(cv[7:0]) << 1) + (10'(s) << 5);
			r = (10'(cv[15:8]) << 1) + (10'(s) << 5);
		end else begin
			l = 10'(s) << 7;
			r = 10'(s) << 7;
		end
		a.left  = {l, 6'b000000};
		a.right = {r, 6'b000000};
		return a;
	endfunction

	////////// Bus and stimulus //////////
	task automatic bus_write(input logic to_sys, input bk_io_pkg::word_t data,
			input logic [1:0] be);
		@(negedge clk_sys);
		bus          = '0;
		bus.stb      = 1'b1;
		bus.we       = 1'b1;
		bus.sel_sys  = to_sys;
		bus.sel_port = !to_sys;
		bus.wtbt     = be;
		bus.dout     = data;
		@(negedge clk_sys);
		bus = '0;
	endtask

	task automatic bus_read(input logic to_sys, input bk_io_pkg::word_t exp);
		@(negedge clk_sys);
		bus          = '0;
		bus.stb      = 1'b1;
		bus.sel_sys  = to_sys;
		bus.sel_port = !to_sys;
		@(negedge clk_sys);
		check_word(exp, rd_data);
		bus = '0;
	endtask

	task automatic send_report(input logic [1:0] btn, input logic signed [8:0] dx,
			input logic signed [8:0] dy);
		@(negedge clk_sys);
		mouse.toggle  = ~mouse.toggle;
		mouse.buttons = btn;
		mouse.dx      = dx;
		mouse.dy      = dy;
	endtask

	// Audio lags the speaker register by one cycle
	task automatic check_mix();
		@(negedge clk_sys);
		check_audio(mix_expect(spk_exp, covox_exp, covox_en), audio);
	endtask

	task automatic wait_pulse();
		int k;
		k = 0;
		@(negedge clk_sys);
		while (!ce_cpu_p && k < 80) begin
			@(negedge clk_sys);
			k++;
		end
		if (!ce_cpu_p) begin
			errors++;
			$display("%s: the CPU clock enable pulse never appeared", test_name);
		end
	endtask

	task automatic measure_ce(input int exp_p, input int skip);
		int n;
		int n_half;
		repeat (skip) wait_pulse();
		wait_pulse();
		n      = 0;
		n_half = 0;
		do begin
			@(negedge clk_sys);
			n++;
			if (ce_cpu_n && n_half == 0)
				n_half = n;
		end while (!ce_cpu_p && n < 80);
		check_word(bk_io_pkg::word_t'(exp_p), bk_io_pkg::word_t'(n));
		check_word(bk_io_pkg::word_t'(exp_p / 2), bk_io_pkg::word_t'(n_half));
	endtask

	////////// Tests //////////
	task automatic test_clock();
		test_name = "clock_enables";
		measure_ce(24, 0);
		// Turbo request is held off while a bus cycle runs
		bus_sync  = 1'b1;
		turbo_req = 1'b1;
		measure_ce(24, 3);
		bus_sync = 1'b0;
		measure_ce(12, 2);
		bk0010 = 1'b1;
		measure_ce(16, 2);
		turbo_req = 1'b0;
		measure_ce(32, 2);
		bk0010 = 1'b0;
	endtask

	task automatic test_sysreg();
		test_name = "sysreg_read";
		key_down  = 1'b0;
		bus_read(1'b1, sys_word(1'b0, 1'b0));
		bus_write(1'b1, 16'h0000, 2'b00);
		bus_read(1'b1, sys_word(1'b0, 1'b1));
		bus_read(1'b1, sys_word(1'b0, 1'b0));
		key_down = 1'b1;
		bus_read(1'b1, sys_word(1'b1, 1'b0));
		key_down = 1'b0;
	endtask

	task automatic test_speaker();
		test_name = "speaker_audio";
		bus_write(1'b1, 16'h0064, 2'b01);
		spk_exp = 3'b111;
		check_mix();
		// Guard bit with the high byte enabled blocks the speaker
		bus_write(1'b1, 16'h0800, 2'b11);
		check_mix();
		bus_write(1'b1, 16'h0020, 2'b11);
		spk_exp = 3'b010;
		check_mix();
		bus_write(1'b1, 16'h0864, 2'b01);
		spk_exp = 3'b111;
		check_mix();
		bk0010 = 1'b1;
		bus_write(1'b1, 16'h0064, 2'b01);
		spk_exp = 3'b110;
		check_mix();
		bus_write(1'b1, 16'h0000, 2'b10);
		check_mix();
		bk0010 = 1'b0;
	endtask

	task automatic test_covox();
		bk_io_pkg::word_t data;
		logic [1:0]       be;
		test_name = "covox";
		covox_en  = 1'b1;
		for (int i = 0; i < 3; i++) begin
			be   = 2'(i + 1);
			data = bk_io_pkg::word_t'($urandom);
			bus_write(1'b0, data, be);
			if (be[0])
				covox_exp[7:0] = data[7:0];
			if (be[1])
				covox_exp[15:8] = data[15:8];
			check_mix();
		end
		covox_en = 1'b0;
	endtask

	task automatic test_port();
		bk_io_pkg::word_t j;
		test_name = "mouse_port";
		bus_write(1'b0, 16'h0008, 2'b01);
		send_report(2'b01, -9'sd4, 9'sd5);
		bus_read(1'b0, 16'h0029);
		// Disable clears the motion bits and ignores motion
		bus_write(1'b0, 16'h0000, 2'b01);
		bus_read(1'b0, 16'h0020);
		send_report(2'b00, 9'sd8, 9'sd8);
		bus_read(1'b0, 16'h0000);
		bus_write(1'b0, 16'h0008, 2'b01);
		send_report(2'b10, -9'sd3, 9'sd3);
		bus_read(1'b0, 16'h0040);
		send_report(2'b00, 9'sd4, -9'sd3);
		bus_read(1'b0, 16'h0002);
		send_report(2'b00, 9'sd0, -9'sd4);
		bus_read(1'b0, 16'h0006);
		send_report(2'b00, 9'sd0, 9'sd5);
		bus_read(1'b0, 16'h0006);
		test_name = "joystick_port";
		j         = bk_io_pkg::word_t'($urandom) | 16'h0001;
		joystick  = j;
		bus_read(1'b0, j);
		joystick = '0;
	endtask

	task automatic test_stop();
		test_name = "stop_key";
		key_stop  = 1'b1;
		bus_write(1'b1, 16'h0000, 2'b10);
		check_bit(1'b1, irq_stop);
		bus_write(1'b1, 16'h1000, 2'b10);
		check_bit(1'b0, irq_stop);
		// Guard bit keeps the block set even with bit 12 clear
		bus_write(1'b1, 16'h0800, 2'b10);
		check_bit(1'b0, irq_stop);
		bus_write(1'b1, 16'h0000, 2'b10);
		check_bit(1'b1, irq_stop);
	endtask

	initial begin
		void'($urandom(32'h5d34a917));
		errors    = 0;
		test_name = "reset";
		spk_exp   = '0;
		covox_exp = '0;
		rst       = 1'b1;
		bus       = '0;
		bus_sync  = 1'b0;
		bk0010    = 1'b0;
		turbo_req = 1'b0;
		covox_en  = 1'b0;
		key_down  = 1'b0;
		key_stop  = 1'b0;
		joystick  = '0;
		mouse     = '0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		rst = 1'b0;
		check_word('0, rd_data);
		check_audio('0, audio);

		test_clock();
		test_sysreg();
		test_speaker();
		test_covox();
		test_port();
		test_stop();

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: bk_io.f
bk_io_pkg.sv
bk_clock_enables.sv
bk_sysreg.sv
bk_port_io.sv
bk_audio_mix.sv
bk_io.sv
tb_bk_io.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_bk_io
FILELIST  ?= bk_io.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
